// ==== design/dphy_lane_pkg.sv ====
package dphy_lane_pkg;

// Leader byte that opens every high-speed burst
// Sent least significant bit first on each lane
localparam logic [7:0] SYNC_BYTE = 8'hB8;

// Largest lane-to-lane skew in byte clocks
// Also the depth of the per-lane delay line in the deskew
localparam int MAX_SKEW = 3;

// Cycles allowed between the first and the last lane becoming valid
localparam int ALIGN_TIMEOUT = 8;

// Counter widths derived from the limits above
localparam int SKEW_CNT_W    = $clog2( MAX_SKEW + 1 );
localparam int TIMEOUT_CNT_W = $clog2( ALIGN_TIMEOUT + 1 );

// One byte of one lane with its qualifier
typedef struct packed {
  logic       valid;
  logic [7:0] data;
} lane_byte_t;

endpackage

// ==== design/dphy_stream_pkg.sv ====
package dphy_stream_pkg;

// Bytes packed into one output word
localparam int WORD_BYTES = 4;

// Width of the output data bus
localparam int WORD_W = WORD_BYTES * 8;

// One output beat
// Byte n of the packet sits at bits 8*(n mod 4) upward
typedef struct packed {
  logic                valid;
  logic [WORD_W - 1:0] data;
} word_beat_t;

endpackage

// ==== design/dphy_byte_align.sv ====
`timescale 1ns/1ps

module dphy_byte_align
  import dphy_lane_pkg::*;
(
  input  logic       byte_clk,
  input  logic       clk_loss_rst_d2,
  // Raw deserializer byte, bit 0 is the earliest bit on the wire
  input  logic [7:0] unaligned_byte_i,
  input  logic       hs_data_valid_i,
  input  logic       reset_align_i,
  output lane_byte_t aligned_o
);

// Previous raw byte, lower half of the search window
logic [7:0]  prev_byte;
// Two consecutive raw bytes, earliest bit at index 0
logic [15:0] window;
// Leader found and byte boundary fixed
logic        locked;
logic [2:0]  offset;
// Search result for the current window
logic        found;
logic [2:0]  found_offset;
logic        drop_lock;

assign window    = { unaligned_byte_i, prev_byte };
assign drop_lock = !hs_data_valid_i || reset_align_i;

always_ff @( posedge byte_clk )
  prev_byte <= unaligned_byte_i;

// Look for the leader at every bit offset of the window
// The lowest offset wins when more than one matches
always_comb
  begin
    found        = 1'b0;
    found_offset = 3'd0;
    for( int i = 7; i >= 0; i-- )
      begin
        if( window[i +: 8] == SYNC_BYTE )
          begin
            found        = 1'b1;
            found_offset = 3'( i );
          end
      end
  end

// Hunt while in high-speed mode, then hold the offset until the burst ends
// or the deskew asks for a new search
always_ff @( posedge byte_clk, posedge clk_loss_rst_d2 )
  if( clk_loss_rst_d2 )
    begin
      locked <= 1'b0;
      offset <= 3'd0;
    end
  else
    if( drop_lock )
      locked <= 1'b0;
    else
      if( !locked && found )
        begin
          locked <= 1'b1;
          offset <= found_offset;
        end

// Once locked the window at the stored offset holds the next payload byte
// The leader itself is never forwarded
assign aligned_o.valid = locked;
assign aligned_o.data  = window[offset +: 8];

endmodule

// ==== design/dphy_word_align.sv ====
`timescale 1ns/1ps

module dphy_word_align
  import dphy_lane_pkg::*;
#(
  parameter int DATA_LANES = 2
)(
  input  logic                          byte_clk,
  input  logic                          clk_loss_rst_d2,
  input  logic                          eop_i,
  input  lane_byte_t [DATA_LANES - 1:0] lanes_i,
  // Restart request to every byte aligner
  output logic                          reset_align_o,
  output lane_byte_t [DATA_LANES - 1:0] lanes_o
);

// Delay line, entry k holds the lanes delayed by k + 1 cycles
lane_byte_t [DATA_LANES - 1:0]                   dly_line [MAX_SKEW];
// Cycles each lane was valid before the last lane arrived
logic       [DATA_LANES - 1:0][SKEW_CNT_W - 1:0] lead_cnt;
logic       [TIMEOUT_CNT_W - 1:0]                wait_cnt;
logic                                            locked;
logic       [DATA_LANES - 1:0]                   in_valid;
logic                                            any_valid;
logic                                            all_valid;
// Each lane read from the tap that matches its lead
lane_byte_t [DATA_LANES - 1:0]                   tap;
logic       [DATA_LANES - 1:0]                   tap_valid;
logic                                            tap_all_valid;
logic                                            desk_valid;
logic                                            hunting;
logic                                            clear_align;
// Fixed output pipeline so lanes leave MAX_SKEW cycles after the last lane
logic                                            pipe_valid [MAX_SKEW];
logic       [DATA_LANES - 1:0][7:0]              pipe_data  [MAX_SKEW];

always_comb
  begin
    for( int l = 0; l < DATA_LANES; l++ )
      in_valid[l] = lanes_i[l].valid;
  end

assign any_valid = |in_valid;
assign all_valid = &in_valid;

// Tap selection
always_comb
  begin
    for( int l = 0; l < DATA_LANES; l++ )
      begin
        if( lead_cnt[l] == '0 )
          tap[l] = lanes_i[l];
        else
          tap[l] = dly_line[lead_cnt[l] - 1'b1][l];
        tap_valid[l] = tap[l].valid;
      end
  end

assign tap_all_valid = &tap_valid;
assign desk_valid    = ( locked || all_valid ) && tap_all_valid;

// Some lanes are up but not all of them yet
assign hunting     = !locked && any_valid && !all_valid;
assign clear_align = eop_i || reset_align_o ||
                     ( locked && !tap_all_valid ) ||
                     ( !locked && !any_valid );

always_ff @( posedge byte_clk )
  begin
    dly_line[0] <= lanes_i;
    for( int k = 1; k < MAX_SKEW; k++ )
      dly_line[k] <= dly_line[k - 1];
  end

always_ff @( posedge byte_clk, posedge clk_loss_rst_d2 )
  if( clk_loss_rst_d2 )
    begin
      locked        <= 1'b0;
      lead_cnt      <= '0;
      wait_cnt      <= '0;
      reset_align_o <= 1'b0;
    end
  else
    begin
      // One-cycle pulse when the slowest lane is too late
      reset_align_o <= hunting &&
                       ( wait_cnt == TIMEOUT_CNT_W'( ALIGN_TIMEOUT - 1 ) );
      if( clear_align )
        begin
          locked   <= 1'b0;
          lead_cnt <= '0;
          wait_cnt <= '0;
        end
      else
        if( hunting )
          begin
            wait_cnt <= wait_cnt + 1'b1;
            // Saturate so the tap index stays inside the delay line
            for( int l = 0; l < DATA_LANES; l++ )
              if( in_valid[l] && ( lead_cnt[l] != SKEW_CNT_W'( MAX_SKEW ) ) )
                lead_cnt[l] <= lead_cnt[l] + 1'b1;
          end
        else
          if( all_valid )
            locked <= 1'b1;
    end

always_ff @( posedge byte_clk, posedge clk_loss_rst_d2 )
  if( clk_loss_rst_d2 )
    begin
      for( int k = 0; k < MAX_SKEW; k++ )
        pipe_valid[k] <= 1'b0;
    end
  else
    begin
      pipe_valid[0] <= desk_valid;
      for( int k = 1; k < MAX_SKEW; k++ )
        pipe_valid[k] <= pipe_valid[k - 1];
    end

always_ff @( posedge byte_clk )
  begin
    for( int l = 0; l < DATA_LANES; l++ )
      pipe_data[0][l] <= tap[l].data;
    for( int k = 1; k < MAX_SKEW; k++ )
      pipe_data[k] <= pipe_data[k - 1];
  end

// All lanes share one valid at the output
always_comb
  begin
    for( int l = 0; l < DATA_LANES; l++ )
      begin
        lanes_o[l].valid = pipe_valid[MAX_SKEW - 1];
        lanes_o[l].data  = pipe_data[MAX_SKEW - 1][l];
      end
  end

endmodule

// ==== design/dphy_32b_map.sv ====
`timescale 1ns/1ps

module dphy_32b_map
  import dphy_lane_pkg::*;
  import dphy_stream_pkg::*;
#(
  parameter int DATA_LANES = 2
)(
  input  logic                          byte_clk,
  input  logic                          clk_loss_rst_d2,
  input  logic                          eop_i,
  input  lane_byte_t [DATA_LANES - 1:0] lanes_i,
  output word_beat_t                    beat_o
);

localparam int FILL_W = $clog2( WORD_BYTES + 1 );

logic [DATA_LANES - 1:0]             in_valid;
logic                                lanes_valid;
// Bytes already collected in the current word
logic [FILL_W - 1:0]                 fill_q;
logic [FILL_W - 1:0]                 fill_next;
logic [WORD_BYTES - 1:0][7:0]        acc_q;
logic [WORD_BYTES - 1:0][7:0]        acc_next;
// Word with unused byte positions forced to zero
logic [WORD_BYTES - 1:0][7:0]        word_out;
logic                                emit;
logic                                beat_valid_q;
logic [WORD_W - 1:0]                 beat_data_q;

always_comb
  begin
    for( int l = 0; l < DATA_LANES; l++ )
      in_valid[l] = lanes_i[l].valid;
  end

assign lanes_valid = &in_valid;

// Lane 0 carries the earliest byte of each cycle
always_comb
  begin
    acc_next  = acc_q;
    fill_next = fill_q;
    if( lanes_valid )
      begin
        for( int l = 0; l < DATA_LANES; l++ )
          acc_next[fill_q + FILL_W'( l )] = lanes_i[l].data;
        fill_next = fill_q + FILL_W'( DATA_LANES );
      end
  end

// Full word, or the tail of a packet on eop
assign emit = ( fill_next == FILL_W'( WORD_BYTES ) ) ||
              ( eop_i && ( fill_next != '0 ) );

always_comb
  begin
    for( int b = 0; b < WORD_BYTES; b++ )
      if( FILL_W'( b ) < fill_next )
        word_out[b] = acc_next[b];
      else
        word_out[b] = 8'h00;
  end

always_ff @( posedge byte_clk, posedge clk_loss_rst_d2 )
  if( clk_loss_rst_d2 )
    begin
      fill_q       <= '0;
      beat_valid_q <= 1'b0;
    end
  else
    begin
      beat_valid_q <= emit;
      if( emit || eop_i )
        fill_q <= '0;
      else
        fill_q <= fill_next;
    end

always_ff @( posedge byte_clk )
  begin
    acc_q <= acc_next;
    if( emit )
      beat_data_q <= word_out;
  end

assign beat_o.valid = beat_valid_q;
assign beat_o.data  = beat_data_q;

endmodule

// ==== design/dphy_rx_backend.sv ====
`timescale 1ns/1ps

module dphy_rx_backend
  import dphy_lane_pkg::*;
  import dphy_stream_pkg::*;
#(
  parameter int DATA_LANES = 2
)(
  input  logic                          byte_clk,
  input  logic                          clk_loss_rst_d2,
  // Raw bytes from the deserializers, one per lane
  input  logic [DATA_LANES - 1:0][7:0]  unaligned_byte_i,
  // Settled high-speed valid, already in the byte clock domain
  input  logic [DATA_LANES - 1:0]       hs_data_valid_i,
  input  logic                          eop_i,
  output word_beat_t                    beat_o
);

// Byte-aligned lanes, still skewed
lane_byte_t [DATA_LANES - 1:0] aligned_lanes;
// Lanes in step with each other
lane_byte_t [DATA_LANES - 1:0] deskewed_lanes;
// Deskew timeout, restarts every leader search
logic                          reset_align;

generate
  for( genvar i = 0; i < DATA_LANES; i++ )
    begin : lane
      dphy_byte_align byte_align
      (
        .byte_clk         ( byte_clk            ),
        .clk_loss_rst_d2  ( clk_loss_rst_d2     ),
        .unaligned_byte_i ( unaligned_byte_i[i] ),
        .hs_data_valid_i  ( hs_data_valid_i[i]  ),
        .reset_align_i    ( reset_align         ),
        .aligned_o        ( aligned_lanes[i]    )
      );
    end
endgenerate

dphy_word_align #(
  .DATA_LANES      ( DATA_LANES      )
) word_align (
  .byte_clk        ( byte_clk        ),
  .clk_loss_rst_d2 ( clk_loss_rst_d2 ),
  .eop_i           ( eop_i           ),
  .lanes_i         ( aligned_lanes   ),
  .reset_align_o   ( reset_align     ),
  .lanes_o         ( deskewed_lanes  )
);

dphy_32b_map #(
  .DATA_LANES      ( DATA_LANES      )
) mapper (
  .byte_clk        ( byte_clk        ),
  .clk_loss_rst_d2 ( clk_loss_rst_d2 ),
  .eop_i           ( eop_i           ),
  .lanes_i         ( deskewed_lanes  ),
  .beat_o          ( beat_o          )
);

endmodule

// ==== dv/tb_dphy_rx_backend.sv ====
`timescale 1ns/1ps

module tb_dphy_rx_backend
  import dphy_lane_pkg::*;
  import dphy_stream_pkg::*;
();

localparam int DATA_LANES = 2;
// Cycles of raw stimulus per packet and the largest payload
localparam int MAX_CYC    = 32;
localparam int MAX_BYTES  = 32;

logic                         byte_clk;
logic                         clk_loss_rst_d2;
logic [DATA_LANES - 1:0][7:0] unaligned_byte;
logic [DATA_LANES - 1:0]      hs_data_valid;
logic                         eop;
word_beat_t                   beat;

// Lane model output, one raw byte and one valid per lane and cycle
logic [7:0]  raw_mem [DATA_LANES][MAX_CYC];
logic        hs_mem  [DATA_LANES][MAX_CYC];
logic [7:0]  payload [MAX_BYTES];
logic [31:0] exp_mem [MAX_BYTES / 4];
logic [31:0] got_q [$];
int          err_cnt;
int          test_cnt;
int          bad_test_cnt;

dphy_rx_backend #(
  .DATA_LANES       ( DATA_LANES      )
) u_dut (
  .byte_clk         ( byte_clk        ),
  .clk_loss_rst_d2  ( clk_loss_rst_d2 ),
  .unaligned_byte_i ( unaligned_byte  ),
  .hs_data_valid_i  ( hs_data_valid   ),
  .eop_i            ( eop             ),
  .beat_o           ( beat            )
);

initial
  begin
    byte_clk = 1'b0;
    forever
      #2 byte_clk = ~byte_clk;
  end

// Beats are registered, so the falling edge sees a settled value
always @( negedge byte_clk )
  if( beat.valid )
    got_q.push_back( beat.data );

task automatic next_cycle();
  @( posedge byte_clk );
  #1;
endtask

task automatic drive_idle( input int cycles );
  for( int i = 0; i < cycles; i++ )
    begin
      next_cycle();
      unaligned_byte = '0;
      hs_data_valid  = '0;
      eop            = 1'b0;
    end
endtask

task automatic pulse_eop();
  next_cycle();
  eop = 1'b1;
  next_cycle();
  eop = 1'b0;
endtask

task automatic fill_payload( input int n_bytes );
  for( int m = 0; m < MAX_BYTES; m++ )
    payload[m] = ( m < n_bytes ) ? 8'( $urandom ) : 8'h00;
endtask

// Serial stream of one lane: a zero byte, offset idle bits, leader, lane bytes
task automatic build_lane( input int lane, input int n_bytes, input int offset,
                           input int delay, input int keep, input bit with_leader );
  logic [8 * MAX_CYC - 1:0] bits;
  int                       pos;
  int                       t_lock;
  int                       local_c;
  bits = '0;
  for( int i = 0; i < offset; i++ )
    bits[8 + i] = 1'( $urandom );
  // Idle bits that happen to spell the leader are cleared
  for( int p = 0; p + 8 <= 8 + offset; p++ )
    if( bits[p +: 8] == SYNC_BYTE )
      bits[15:8] = 8'h00;
  pos = 8 + offset;
  if( with_leader )
    begin
      bits[pos +: 8] = SYNC_BYTE;
      pos = pos + 8;
      for( int m = lane; m < n_bytes; m += DATA_LANES )
        begin
          bits[pos +: 8] = payload[m];
          pos = pos + 8;
        end
    end
  // The leader is seen in the cycle of the raw byte after the one it starts in
  t_lock = ( 8 + offset ) / 8 + 1;
  for( int c = 0; c < MAX_CYC; c++ )
    begin
      local_c = c - delay;
      if( local_c < 0 )
        begin
          raw_mem[lane][c] = 8'h00;
          hs_mem[lane][c]  = 1'b0;
        end
      else
        begin
          raw_mem[lane][c] = bits[8 * local_c +: 8];
          hs_mem[lane][c]  = ( local_c < t_lock + keep );
        end
    end
endtask

// Stream byte m goes to word m/4 at bit 8*(m mod 4), unused bytes stay zero
task automatic pack_reference( input int n_bytes );
  for( int w = 0; w < MAX_BYTES / 4; w++ )
    exp_mem[w] = '0;
  for( int m = 0; m < n_bytes; m++ )
    exp_mem[m / 4][8 * ( m % 4 ) +: 8] = payload[m];
endtask

task automatic load_packet( input int n_bytes, input int offset, input int skew,
                            input int keep, input bit lane1_leader );
  fill_payload( n_bytes );
  build_lane( 0, n_bytes, offset, 0, keep, 1'b1 );
  build_lane( 1, n_bytes, offset, skew, keep, lane1_leader );
  pack_reference( n_bytes );
endtask

task automatic play_lanes( input int cycles );
  for( int c = 0; c < cycles; c++ )
    begin
      next_cycle();
      for( int l = 0; l < DATA_LANES; l++ )
        begin
          unaligned_byte[l] = raw_mem[l][c];
          hs_data_valid[l]  = hs_mem[l][c];
        end
    end
endtask

task automatic wait_beats( input int count, input int limit );
  int waited;
  waited = 0;
  while( ( got_q.size() < count ) && ( waited < limit ) )
    begin
      drive_idle( 1 );
      waited++;
    end
  if( got_q.size() < count )
    begin
      $display( "Timed out after %0d cycles while waiting for beat %0d", limit, count );
      err_cnt++;
    end
endtask

task automatic check_beats( input int exp_count );
  int n;
  assert( got_q.size() == exp_count )
  else
    begin
      $display( "Received %0d beats where %0d were expected", got_q.size(), exp_count );
      err_cnt++;
    end
  n = ( got_q.size() < exp_count ) ? got_q.size() : exp_count;
  for( int i = 0; i < n; i++ )
    assert( got_q[i] == exp_mem[i] )
    else
      begin
        $display( "Error: beat_o.data word %0d expected %h actual %h", i, exp_mem[i],
                  got_q[i] );
        err_cnt++;
      end
endtask

task automatic run_packet( input int n_bytes, input int offset, input int skew,
                           input int keep, input bit lane1_leader, input bit send_eop,
                           input int exp_count );
  int full;
  load_packet( n_bytes, offset, skew, keep, lane1_leader );
  got_q.delete();
  play_lanes( MAX_CYC );
  full = send_eop ? n_bytes / 4 : exp_count;
  wait_beats( full, 40 );
  if( send_eop )
    begin
      drive_idle( 2 );
      pulse_eop();
      wait_beats( exp_count, 40 );
    end
  // Quiet window in which no further beat may show up
  drive_idle( 20 );
  check_beats( exp_count );
endtask

task automatic report_test( input string name, input int err_before );
  test_cnt++;
  if( err_cnt == err_before )
    $display( "[pass] %s", name );
  else
    begin
      bad_test_cnt++;
      $display( "[FAIL] %s, %0d errors", name, err_cnt - err_before );
    end
endtask

task automatic test_offset_sweep();
  int err_before;
  err_before = err_cnt;
  for( int o = 0; o < 8; o++ )
    run_packet( 8, o, 0, 4, 1'b1, 1'b1, 2 );
  report_test( "offset sweep", err_before );
endtask

task automatic test_lane_skew();
  int err_before;
  err_before = err_cnt;
  for( int d = 0; d <= MAX_SKEW; d++ )
    run_packet( 8, ( 2 * d + 1 ) % 8, d, 4, 1'b1, 1'b1, 2 );
  report_test( "lane skew", err_before );
endtask

task automatic test_end_of_packet();
  int err_before;
  err_before = err_cnt;
  // Second word carries bytes 4 and 5 with a zero upper half
  run_packet( 6, 5, 1, 3, 1'b1, 1'b1, 2 );
  report_test( "end of packet", err_before );
endtask

task automatic test_missing_lane();
  int err_before;
  err_before = err_cnt;
  // Lane 0 stays up long enough for the deskew timeout to fire
  run_packet( 24, 2, 0, 12, 1'b0, 1'b0, 0 );
  // Lane 1 locks only after the timeout has already released lane 0
  run_packet( 16, 2, 10, 14, 1'b1, 1'b0, 0 );
  run_packet( 8, 6, 2, 4, 1'b1, 1'b1, 2 );
  report_test( "missing lane", err_before );
endtask

task automatic test_dropped_valid();
  int err_before;
  err_before = err_cnt;
  // Four bytes per lane reach the DUT, exactly two words
  run_packet( 16, 6, 1, 4, 1'b1, 1'b0, 2 );
  run_packet( 8, 1, 0, 4, 1'b1, 1'b1, 2 );
  report_test( "dropped hs valid", err_before );
endtask

task automatic test_reset_mid_packet();
  int err_before;
  err_before = err_cnt;
  load_packet( 16, 5, 2, 8, 1'b1 );
  play_lanes( 10 );
  next_cycle();
  clk_loss_rst_d2 = 1'b1;
  unaligned_byte  = '0;
  hs_data_valid   = '0;
  for( int i = 0; i < 5; i++ )
    begin
      #1;
      assert( beat.valid == 1'b0 )
      else
        begin
          $display( "Error: beat_o.valid expected 0 actual %h", beat.valid );
          err_cnt++;
        end
      next_cycle();
    end
  clk_loss_rst_d2 = 1'b0;
  drive_idle( 5 );
  run_packet( 8, 4, 1, 4, 1'b1, 1'b1, 2 );
  report_test( "reset mid packet", err_before );
endtask

initial
  begin
    void'( $urandom( 32'h675f9ed2 ) );
    clk_loss_rst_d2 = 1'b1;
    unaligned_byte  = '0;
    hs_data_valid   = '0;
    eop             = 1'b0;
    err_cnt         = 0;
    test_cnt        = 0;
    bad_test_cnt    = 0;
    repeat( 5 ) @( posedge byte_clk );
    #1;
    clk_loss_rst_d2 = 1'b0;
    drive_idle( 3 );
    test_offset_sweep();
    test_lane_skew();
    test_end_of_packet();
    test_missing_lane();
    test_dropped_valid();
    test_reset_mid_packet();
    $display( "%0d tests run, %0d with errors, %0d errors in total", test_cnt,
              bad_test_cnt, err_cnt );
    if( err_cnt == 0 )
      $display( "Test completed successfully" );
    else
      $display( "Test failed" );
    $finish;
  end

endmodule

// ==== files.f ====
design/dphy_lane_pkg.sv
design/dphy_stream_pkg.sv
design/dphy_byte_align.sv
design/dphy_word_align.sv
design/dphy_32b_map.sv
design/dphy_rx_backend.sv
dv/tb_dphy_rx_backend.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_dphy_rx_backend -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Test completed successfully" "$LOG"; then
  echo "No pass line found in $LOG"
  exit 1
fi
exit 0
